// ==== source/sys1_defs.svh ====
// Clock divider count, I/O port addresses, memory regions and decrypt table download constants
`ifndef SYS1_DEFS_SVH
`define SYS1_DEFS_SVH

// Last count of the CPU clock divider, 40 MHz / 10 = 4 MHz
`define SYS1_CLKDIV_LAST 9

// Sound request port, decoded at two mirrors
`define SYS1_IO_SNDREQ_A 8'h14
`define SYS1_IO_SNDREQ_B 8'h18

// Video mode latch port, same mirroring as the sound port
`define SYS1_IO_VIDMODE_A 8'h15
`define SYS1_IO_VIDMODE_B 8'h19

// Encrypted program ROM, A15 low
`define SYS1_ROM_ENC_REGION 1'b0

// Plain program ROM, A15..A14
`define SYS1_ROM_PLAIN_REGION 2'b10

// Work RAM at C000-CFFF, A15..A12
`define SYS1_RAM_REGION 4'hC

// Decrypt table location inside the downloaded ROM image
`define SYS1_DECTBL_BASE 25'h1F000

// One entry per index value
`define SYS1_DECTBL_ENTRIES 32

// Only data bits 7, 5 and 3 are scrambled
`define SYS1_DECRYPT_MASK 8'hA8

`endif

// ==== source/sys1_bus_pkg.sv ====
// CPU bus vector types and the read data source enum
package sys1_bus_pkg;

	// Z80 address bus
	typedef logic [15:0] cpu_addr_t;

	// Data bus byte, shared by reads, writes and the switch ports
	typedef logic [7:0] cpu_data_t;

	// Work RAM word address, 4 KiB
	typedef logic [11:0] ram_addr_t;

	// Source of the byte on cpu_rdata, listed in priority order
	typedef enum logic [2:0] {
		VIDEO,
		VIDMODE,
		PORT,
		RAM,
		ROM_ENC,
		ROM_PLAIN,
		OPEN_BUS
	} read_source_e;

endpackage

// ==== source/sys1_rom_pkg.sv ====
// Program ROM, download address and decrypt table types
package sys1_rom_pkg;

	// Address into the downloaded ROM image
	typedef logic [24:0] rom_load_addr_t;

	// {M1, A12, A8, A4, A0}
	typedef logic [4:0] dectbl_index_t;

	// One decrypt table byte
	typedef logic [7:0] dectbl_entry_t;

	// External program ROM address
	typedef logic [15:0] rom_addr_t;

	// Lower 32 KiB, bit 15 dropped
	typedef logic [$bits(rom_addr_t)-2:0] rom_addr_enc_t;

endpackage

// ==== source/sys1_clock_enable.sv ====
// 4 MHz CPU clock enable from the 40 MHz master clock
`timescale 1ns/1ps
`include "sys1_defs.svh"

module sys1_clock_enable (
	input  logic CLK40M,
	input  logic RESET,
	output logic clk_en
);

	logic [4:0] div_cnt;
	logic       div_wrap;

	assign div_wrap = (div_cnt == 5'(`SYS1_CLKDIV_LAST));

	// Counter wraps at the last count, pulse is registered on the wrap
	always_ff @(posedge CLK40M or posedge RESET) begin
		if (RESET) begin
			div_cnt <= '0;
			clk_en  <= 1'b0;
		end else begin
			clk_en <= div_wrap;
			if (div_wrap) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 5'd1;
			end
		end
	end

	// Pulses are isolated and come exactly ten cycles apart
	a_clk_en_period: assert property (
		@(posedge CLK40M) disable iff (RESET)
		clk_en |=> (!clk_en) [*`SYS1_CLKDIV_LAST] ##1 clk_en
	);

endmodule

// ==== source/sys1_input_ports.sv ====
// Player input and DIP switch port decode and read selection
`timescale 1ns/1ps

module sys1_input_ports (
	input  sys1_bus_pkg::cpu_addr_t cpu_addr,
	input  logic                    cpu_iorq,
	input  sys1_bus_pkg::cpu_data_t inp0,
	input  sys1_bus_pkg::cpu_data_t inp1,
	input  sys1_bus_pkg::cpu_data_t inp2,
	input  sys1_bus_pkg::cpu_data_t dsw0,
	input  sys1_bus_pkg::cpu_data_t dsw1,
	output logic                    hit,
	output sys1_bus_pkg::cpu_data_t port_data
);

	import sys1_bus_pkg::*;

	logic [2:0] port_sel;
	logic       cs_inp0;
	logic       cs_inp1;
	logic       cs_inp2;
	logic       cs_dsw0;
	logic       cs_dsw1;
	cpu_data_t  sel_data;

	// Ports are decoded on A4..A2 only, A0 splits the switch banks
	assign port_sel = cpu_addr[4:2];

	assign cs_inp0 = cpu_iorq && (port_sel == 3'b000);
	assign cs_inp1 = cpu_iorq && (port_sel == 3'b001);
	assign cs_inp2 = cpu_iorq && (port_sel == 3'b010);
	assign cs_dsw0 = cpu_iorq && (port_sel == 3'b011) && !cpu_addr[0];
	// DSW1 also answers at its 10h mirror
	assign cs_dsw1 = cpu_iorq && (((port_sel == 3'b011) && cpu_addr[0]) ||
		(port_sel == 3'b100));

	always_comb begin
		sel_data = 8'hFF;
		if (cs_inp0) begin
			sel_data = inp0;
		end else if (cs_inp1) begin
			sel_data = inp1;
		end else if (cs_inp2) begin
			sel_data = inp2;
		end else if (cs_dsw0) begin
			sel_data = dsw0;
		end else if (cs_dsw1) begin
			sel_data = dsw1;
		end
	end

	assign hit       = cs_inp0 || cs_inp1 || cs_inp2 || cs_dsw0 || cs_dsw1;
	assign port_data = sel_data;

endmodule

// ==== source/sys1_program_decrypt.sv ====
// Downloadable decrypt table and decryption of the encrypted program ROM
`timescale 1ns/1ps
`include "sys1_defs.svh"

module sys1_program_decrypt (
	input  logic                          CLK40M,
	input  logic                          RESET,
	input  logic                          cpu_m1,
	input  sys1_bus_pkg::cpu_addr_t       cpu_addr,
	output sys1_rom_pkg::rom_addr_enc_t   rom_addr_enc,
	input  sys1_bus_pkg::cpu_data_t       rom_data,
	output sys1_bus_pkg::cpu_data_t       dec_data,
	input  sys1_rom_pkg::rom_load_addr_t  rom_load_addr,
	input  sys1_rom_pkg::dectbl_entry_t   rom_load_data,
	input  logic                          rom_load_en
);

	import sys1_bus_pkg::*;
	import sys1_rom_pkg::*;

	localparam rom_load_addr_t tbl_first = `SYS1_DECTBL_BASE;
	localparam rom_load_addr_t tbl_last  =
		tbl_first + rom_load_addr_t'(`SYS1_DECTBL_ENTRIES - 1);
	localparam cpu_data_t      dec_mask  = `SYS1_DECRYPT_MASK;

	dectbl_entry_t dec_table [`SYS1_DECTBL_ENTRIES];
	logic          tbl_wr;
	dectbl_index_t tbl_wr_idx;
	dectbl_index_t dec_idx;
	dectbl_entry_t dec_entry;

	// Table bytes ride along at the end of the ROM download
	assign tbl_wr     = rom_load_en && (rom_load_addr >= tbl_first) &&
		(rom_load_addr <= tbl_last);
	assign tbl_wr_idx = rom_load_addr[4:0];

	// Cleared table passes the ROM through unchanged
	always_ff @(posedge CLK40M or posedge RESET) begin
		if (RESET) begin
			for (int i = 0; i < `SYS1_DECTBL_ENTRIES; i++) begin
				dec_table[i] <= '0;
			end
		end else if (tbl_wr) begin
			dec_table[tbl_wr_idx] <= rom_load_data;
		end
	end

	// Opcode fetches and data reads use separate halves of the table
	assign dec_idx = {cpu_m1, cpu_addr[12], cpu_addr[8], cpu_addr[4], cpu_addr[0]};

	assign dec_entry = dec_table[dec_idx];

	// Address reaches the ROM untouched, only the data is scrambled
	assign rom_addr_enc = cpu_addr[14:0];

	// XOR on bits 7, 5 and 3 only
	assign dec_data = rom_data ^ (dec_entry & dec_mask);

	// Download source must present real data for table bytes
	a_tbl_load_known: assert property (
		@(posedge CLK40M) disable iff (RESET)
		tbl_wr |-> !$isunknown(rom_load_data)
	);

endmodule

// ==== source/sys1_work_ram.sv ====
// 4 KiB main CPU work RAM with registered read
`timescale 1ns/1ps

module sys1_work_ram (
	input  logic                    CLK40M,
	input  sys1_bus_pkg::ram_addr_t addr,
	input  logic                    we,
	input  sys1_bus_pkg::cpu_data_t wdata,
	output sys1_bus_pkg::cpu_data_t rdata
);

	import sys1_bus_pkg::*;

	localparam int ram_words = 2 ** $bits(ram_addr_t);

	cpu_data_t mem [ram_words];

	// Read before write, infers a single port block RAM
	always_ff @(posedge CLK40M) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

// ==== source/sys1_main_board.sv ====
// Main CPU board top level with decode, latches, ROM address mux and read data selector
`timescale 1ns/1ps
`include "sys1_defs.svh"

module sys1_main_board (
	input  logic                         CLK40M,
	input  logic                         RESET,
	input  sys1_bus_pkg::cpu_addr_t      cpu_addr,
	input  sys1_bus_pkg::cpu_data_t      cpu_wdata,
	input  logic                         cpu_m1,
	input  logic                         cpu_mreq,
	input  logic                         cpu_iorq,
	input  logic                         cpu_rd,
	input  logic                         cpu_wr,
	output sys1_bus_pkg::cpu_data_t      cpu_rdata,
	output logic                         cpu_clk_en,
	output logic                         cpu_mem_wr,
	input  sys1_bus_pkg::cpu_data_t      inp0,
	input  sys1_bus_pkg::cpu_data_t      inp1,
	input  sys1_bus_pkg::cpu_data_t      inp2,
	input  sys1_bus_pkg::cpu_data_t      dsw0,
	input  sys1_bus_pkg::cpu_data_t      dsw1,
	input  logic                         vid_cs,
	input  sys1_bus_pkg::cpu_data_t      vid_rdata,
	output sys1_bus_pkg::cpu_data_t      vid_mode,
	output logic                         snd_rq,
	output sys1_bus_pkg::cpu_data_t      snd_no,
	output sys1_rom_pkg::rom_addr_t      rom_addr,
	input  sys1_bus_pkg::cpu_data_t      rom_data,
	input  sys1_rom_pkg::rom_load_addr_t rom_load_addr,
	input  sys1_rom_pkg::dectbl_entry_t  rom_load_data,
	input  logic                         rom_load_en
);

	import sys1_bus_pkg::*;
	import sys1_rom_pkg::*;

	logic          port_hit;
	cpu_data_t     port_data;
	rom_addr_enc_t rom_addr_enc;
	cpu_data_t     dec_data;
	ram_addr_t     ram_addr;
	cpu_data_t     ram_rdata;
	logic          ram_cs;
	logic          rom_enc_cs;
	logic          rom_plain_cs;
	logic          io_wr;
	logic          vidm_sel;
	logic          sreq_sel;
	read_source_e  rd_src;

	sys1_clock_enable i_sys1_clock_enable (
		.CLK40M (CLK40M),
		.RESET  (RESET),
		.clk_en (cpu_clk_en)
	);

	sys1_input_ports i_sys1_input_ports (
		.cpu_addr  (cpu_addr),
		.cpu_iorq  (cpu_iorq),
		.inp0      (inp0),
		.inp1      (inp1),
		.inp2      (inp2),
		.dsw0      (dsw0),
		.dsw1      (dsw1),
		.hit       (port_hit),
		.port_data (port_data)
	);

	sys1_program_decrypt i_sys1_program_decrypt (
		.CLK40M        (CLK40M),
		.RESET         (RESET),
		.cpu_m1        (cpu_m1),
		.cpu_addr      (cpu_addr),
		.rom_addr_enc  (rom_addr_enc),
		.rom_data      (rom_data),
		.dec_data      (dec_data),
		.rom_load_addr (rom_load_addr),
		.rom_load_data (rom_load_data),
		.rom_load_en   (rom_load_en)
	);

	// Memory region decode
	assign rom_enc_cs   = cpu_mreq && (cpu_addr[15] == `SYS1_ROM_ENC_REGION);
	assign rom_plain_cs = cpu_mreq && (cpu_addr[15:14] == `SYS1_ROM_PLAIN_REGION);
	assign ram_cs       = cpu_mreq && (cpu_addr[15:12] == `SYS1_RAM_REGION);

	// Memory write strobe is also used by the video board
	assign cpu_mem_wr = cpu_wr && cpu_mreq;

	assign ram_addr = cpu_addr[11:0];

	sys1_work_ram i_sys1_work_ram (
		.CLK40M (CLK40M),
		.addr   (ram_addr),
		.we     (cpu_mem_wr && ram_cs),
		.wdata  (cpu_wdata),
		.rdata  (ram_rdata)
	);

	// Upper half passes straight through, lower half via the decrypt block
	assign rom_addr = cpu_addr[15] ? cpu_addr : {1'b0, rom_addr_enc};

	// Latch ports, full low byte decode
	assign io_wr    = cpu_iorq && cpu_wr;
	assign vidm_sel = cpu_iorq && ((cpu_addr[7:0] == `SYS1_IO_VIDMODE_A) ||
		(cpu_addr[7:0] == `SYS1_IO_VIDMODE_B));
	assign sreq_sel = cpu_iorq && ((cpu_addr[7:0] == `SYS1_IO_SNDREQ_A) ||
		(cpu_addr[7:0] == `SYS1_IO_SNDREQ_B));

	always_ff @(posedge CLK40M or posedge RESET) begin
		if (RESET) begin
			vid_mode <= '0;
			snd_no   <= '0;
			snd_rq   <= 1'b0;
		end else begin
			if (io_wr && vidm_sel) begin
				vid_mode <= cpu_wdata;
			end
			if (io_wr && sreq_sel) begin
				snd_no <= cpu_wdata;
			end
			// Request pulses once per write cycle
			snd_rq <= io_wr && sreq_sel;
		end
	end

	// Read source, first match wins
	always_comb begin
		if (vid_cs && cpu_mreq) begin
			rd_src = VIDEO;
		end else if (vidm_sel) begin
			rd_src = VIDMODE;
		end else if (port_hit) begin
			rd_src = PORT;
		end else if (ram_cs) begin
			rd_src = RAM;
		end else if (rom_enc_cs) begin
			rd_src = ROM_ENC;
		end else if (rom_plain_cs) begin
			rd_src = ROM_PLAIN;
		end else begin
			rd_src = OPEN_BUS;
		end
	end

	always_comb begin
		case (rd_src)
			VIDEO:     cpu_rdata = vid_rdata;
			VIDMODE:   cpu_rdata = vid_mode;
			PORT:      cpu_rdata = port_data;
			RAM:       cpu_rdata = ram_rdata;
			ROM_ENC:   cpu_rdata = dec_data;
			ROM_PLAIN: cpu_rdata = rom_data;
			default:   cpu_rdata = 8'hFF;
		endcase
	end

	// Z80 never runs a memory and an I/O cycle at once
	a_mreq_iorq_excl: assert property (
		@(posedge CLK40M) disable iff (RESET)
		!(cpu_mreq && cpu_iorq)
	);

	// Read and write strobes are exclusive as well
	a_rd_wr_excl: assert property (
		@(posedge CLK40M) disable iff (RESET)
		!(cpu_rd && cpu_wr)
	);

endmodule

// ==== testbench/tb_sys1_main_board.sv ====
// Table-driven testbench for the main CPU board with clock, reset, bus cycles, checks and timeout
`timescale 1ns/1ps
`include "sys1_defs.svh"

module tb_sys1_main_board;

	import sys1_bus_pkg::*;
	import sys1_rom_pkg::*;

	typedef enum int {
		OP_CLK_GAP, OP_MEM_RD, OP_MEM_WR, OP_IO_RD,
		OP_IO_WR, OP_FETCH, OP_VID_RD, OP_TBL_LOAD
	} bus_op_e;

	logic           CLK40M;
	logic           RESET;
	cpu_addr_t      cpu_addr;
	cpu_data_t      cpu_wdata;
	logic           cpu_m1, cpu_mreq, cpu_iorq, cpu_rd, cpu_wr;
	cpu_data_t      cpu_rdata;
	logic           cpu_clk_en, cpu_mem_wr;
	cpu_data_t      inp0, inp1, inp2, dsw0, dsw1;
	logic           vid_cs;
	cpu_data_t      vid_rdata, vid_mode;
	logic           snd_rq;
	cpu_data_t      snd_no;
	rom_addr_t      rom_addr;
	cpu_data_t      rom_data;
	rom_load_addr_t rom_load_addr;
	dectbl_entry_t  rom_load_data;
	logic           rom_load_en;

	// Stimulus table with one entry per test
	string          row_name [$];
	bus_op_e        row_op   [$];
	cpu_addr_t      row_addr [$];
	cpu_data_t      row_data [$];
	cpu_data_t      row_exp  [$];

	dectbl_entry_t  dec_tbl [`SYS1_DECTBL_ENTRIES];
	logic [31:0]    rng_state;
	int             error_count = 0;
	int             pass_count = 0;
	int             fail_count = 0;
	int             cycle_count = 0;
	int             cycle_limit = 0;

	sys1_main_board i_sys1_main_board (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Program ROM contents as a fixed scramble of the address
	function automatic cpu_data_t rom_byte(input rom_addr_t a);
		logic [31:0] s;
		s = xorshift32(32'd90 ^ {a, 16'h0000});
		s = xorshift32(s);
		return s[7:0] ^ s[23:16];
	endfunction

	function automatic dectbl_index_t dec_index(input logic m1, input cpu_addr_t a);
		return {m1, a[12], a[8], a[4], a[0]};
	endfunction

	function automatic cpu_data_t dec_expect(input logic m1, input cpu_addr_t a);
		return rom_byte(a) ^ (dec_tbl[dec_index(m1, a)] & `SYS1_DECRYPT_MASK);
	endfunction

	// Combinational external ROM
	assign rom_data = rom_byte(rom_addr);

	initial begin
		CLK40M = 1'b0;
		forever #2 CLK40M = ~CLK40M;
	end

	always @(posedge CLK40M) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Test failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input cpu_data_t expected,
		input cpu_data_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("MISMATCH %s: expected %02h, actual %02h", name, expected, actual);
		end
	endtask

	task automatic add_row(input string name, input bus_op_e op, input cpu_addr_t addr,
		input cpu_data_t data, input cpu_data_t exp);
		row_name.push_back(name);
		row_op.push_back(op);
		row_addr.push_back(addr);
		row_data.push_back(data);
		row_exp.push_back(exp);
	endtask

	// One row on the bus with strobes held for three cycles and sampled in the last
	task automatic run_bus_cycle(input string name, input bus_op_e op, input cpu_addr_t addr,
		input cpu_data_t data, output cpu_data_t result);
		int      gap;
		int      idx;
		logic    pulse_seen;
		logic    snd_port;
		bus_op_e cyc_op;
		snd_port = (addr[7:0] == `SYS1_IO_SNDREQ_A) || (addr[7:0] == `SYS1_IO_SNDREQ_B);
		result = 8'h00;
		cyc_op = op;
		if (op == OP_TBL_LOAD) begin
			@(posedge CLK40M);
			#0.5;
			rom_load_en = 1'b1;
			for (idx = 0; idx < `SYS1_DECTBL_ENTRIES; idx++) begin
				rom_load_addr = `SYS1_DECTBL_BASE + rom_load_addr_t'(idx);
				rom_load_data = dec_tbl[idx];
				@(posedge CLK40M);
				#0.5;
			end
			// Writes just outside the table must be ignored
			rom_load_addr = `SYS1_DECTBL_BASE - 25'd1;
			rom_load_data = ~dec_tbl[`SYS1_DECTBL_ENTRIES - 1];
			@(posedge CLK40M);
			#0.5;
			rom_load_addr = `SYS1_DECTBL_BASE + 25'(`SYS1_DECTBL_ENTRIES);
			rom_load_data = ~dec_tbl[0];
			@(posedge CLK40M);
			#0.5;
			rom_load_en = 1'b0;
			// Loaded table is read back through a decrypted data read
			cyc_op = OP_MEM_RD;
		end
		case (cyc_op)
			OP_CLK_GAP: begin
				gap = 0;
				pulse_seen = 1'b0;
				while (!pulse_seen && gap < 64) begin
					@(posedge CLK40M);
					gap++;
					@(negedge CLK40M);
					pulse_seen = cpu_clk_en;
				end
				result = cpu_data_t'(gap);
			end
			default: begin
				@(posedge CLK40M);
				#0.5;
				cpu_addr = addr;
				cpu_wdata = data;
				cpu_m1 = (cyc_op == OP_FETCH);
				cpu_mreq = (cyc_op == OP_MEM_RD) || (cyc_op == OP_MEM_WR) ||
					(cyc_op == OP_FETCH) || (cyc_op == OP_VID_RD);
				cpu_iorq = (cyc_op == OP_IO_RD) || (cyc_op == OP_IO_WR);
				cpu_wr = (cyc_op == OP_MEM_WR) || (cyc_op == OP_IO_WR);
				cpu_rd = !cpu_wr;
				vid_cs = (cyc_op == OP_VID_RD);
				vid_rdata = data;
				repeat (2) @(posedge CLK40M);
				@(negedge CLK40M);
				if (cyc_op == OP_MEM_WR) begin
					result = {7'b0, cpu_mem_wr};
				end else if (cyc_op == OP_IO_WR) begin
					result = snd_port ? snd_no : vid_mode;
					if (snd_port) begin
						check_value({name, " snd_rq held"}, 8'h01, {7'b0, snd_rq});
					end
				end else begin
					result = cpu_rdata;
					// Program ROM sees the CPU address unchanged
					if ((cyc_op == OP_MEM_RD || cyc_op == OP_FETCH) && addr < 16'hC000) begin
						check_value({name, " rom_addr high"}, addr[15:8], rom_addr[15:8]);
						check_value({name, " rom_addr low"}, addr[7:0], rom_addr[7:0]);
					end
				end
				@(posedge CLK40M);
				#0.5;
				{cpu_m1, cpu_mreq, cpu_iorq, cpu_rd, cpu_wr, vid_cs} = '0;
				if (cyc_op == OP_IO_WR && snd_port) begin
					@(posedge CLK40M);
					@(negedge CLK40M);
					check_value({name, " snd_rq released"}, 8'h00, {7'b0, snd_rq});
				end
			end
		endcase
	endtask

	task automatic build_table();
		add_row("clk_en first pulse", OP_CLK_GAP, 16'h0000, 8'h00, 8'd10);
		add_row("clk_en period", OP_CLK_GAP, 16'h0000, 8'h00, 8'd10);
		add_row("inp0 at 00h", OP_IO_RD, 16'h0000, 8'h00, inp0);
		add_row("inp1 at 04h", OP_IO_RD, 16'h0004, 8'h00, inp1);
		add_row("inp2 at 08h", OP_IO_RD, 16'h0008, 8'h00, inp2);
		add_row("dsw0 at 0Ch", OP_IO_RD, 16'h000C, 8'h00, dsw0);
		add_row("dsw1 at 0Dh", OP_IO_RD, 16'h000D, 8'h00, dsw1);
		add_row("dsw1 at 10h", OP_IO_RD, 16'h0010, 8'h00, dsw1);
		add_row("unmapped io 1Ch", OP_IO_RD, 16'h001C, 8'h00, 8'hFF);
		add_row("ram write C000", OP_MEM_WR, 16'hC000, 8'h5A, 8'h01);
		add_row("ram write C321", OP_MEM_WR, 16'hC321, 8'hA5, 8'h01);
		add_row("ram write CABC", OP_MEM_WR, 16'hCABC, 8'h3C, 8'h01);
		add_row("ram write CFFF", OP_MEM_WR, 16'hCFFF, 8'hC3, 8'h01);
		add_row("ram read CFFF", OP_MEM_RD, 16'hCFFF, 8'h00, 8'hC3);
		add_row("ram read CABC", OP_MEM_RD, 16'hCABC, 8'h00, 8'h3C);
		add_row("ram read C321", OP_MEM_RD, 16'hC321, 8'h00, 8'hA5);
		add_row("ram read C000", OP_MEM_RD, 16'hC000, 8'h00, 8'h5A);
		add_row("open bus D000", OP_MEM_RD, 16'hD000, 8'h00, 8'hFF);
		add_row("vid_cs over ram", OP_VID_RD, 16'hC000, 8'h96, 8'h96);
		add_row("rom read 0000 clear", OP_MEM_RD, 16'h0000, 8'h00, rom_byte(16'h0000));
		add_row("rom fetch 1111 clear", OP_FETCH, 16'h1111, 8'h00, rom_byte(16'h1111));
		add_row("rom read 6D91 clear", OP_MEM_RD, 16'h6D91, 8'h00, rom_byte(16'h6D91));
		add_row("decrypt table load", OP_TBL_LOAD, 16'h7EEE, 8'h00,
			dec_expect(1'b0, 16'h7EEE));
		add_row("dec read 0000", OP_MEM_RD, 16'h0000, 8'h00, dec_expect(1'b0, 16'h0000));
		add_row("dec fetch 0000", OP_FETCH, 16'h0000, 8'h00, dec_expect(1'b1, 16'h0000));
		add_row("dec fetch 1111", OP_FETCH, 16'h1111, 8'h00, dec_expect(1'b1, 16'h1111));
		add_row("dec read 1111", OP_MEM_RD, 16'h1111, 8'h00, dec_expect(1'b0, 16'h1111));
		add_row("dec read 6D91", OP_MEM_RD, 16'h6D91, 8'h00, dec_expect(1'b0, 16'h6D91));
		add_row("dec fetch 6D91", OP_FETCH, 16'h6D91, 8'h00, dec_expect(1'b1, 16'h6D91));
		add_row("plain read 8000", OP_MEM_RD, 16'h8000, 8'h00, rom_byte(16'h8000));
		add_row("plain fetch A5C3", OP_FETCH, 16'hA5C3, 8'h00, rom_byte(16'hA5C3));
		add_row("plain read BFFF", OP_MEM_RD, 16'hBFFF, 8'h00, rom_byte(16'hBFFF));
		add_row("vid_mode write 15h", OP_IO_WR, 16'h0015, 8'h81, 8'h81);
		add_row("vid_mode read 15h", OP_IO_RD, 16'h0015, 8'h00, 8'h81);
		add_row("vid_mode write 19h", OP_IO_WR, 16'h0019, 8'h3E, 8'h3E);
		add_row("vid_mode read back", OP_IO_RD, 16'h0015, 8'h00, 8'h3E);
		add_row("sound write 14h", OP_IO_WR, 16'h0014, 8'h47, 8'h47);
		add_row("sound write 18h", OP_IO_WR, 16'h0018, 8'hC2, 8'hC2);
	endtask

	initial begin
		cpu_data_t result;
		int        errs_before;
		int        row;
		int        i;
		RESET = 1'b1;
		cpu_addr = '0;
		cpu_wdata = '0;
		{cpu_m1, cpu_mreq, cpu_iorq, cpu_rd, cpu_wr, vid_cs} = '0;
		vid_rdata = '0;
		rom_load_addr = '0;
		rom_load_data = '0;
		rom_load_en = 1'b0;
		// Switch bytes and then the decrypt table from one sequence
		rng_state = 32'd90;
		rng_state = xorshift32(rng_state);
		inp0 = rng_state[7:0];
		rng_state = xorshift32(rng_state);
		inp1 = rng_state[7:0];
		rng_state = xorshift32(rng_state);
		inp2 = rng_state[7:0];
		rng_state = xorshift32(rng_state);
		dsw0 = rng_state[7:0];
		rng_state = xorshift32(rng_state);
		dsw1 = rng_state[7:0];
		for (i = 0; i < `SYS1_DECTBL_ENTRIES; i++) begin
			rng_state = xorshift32(rng_state);
			dec_tbl[i] = rng_state[7:0];
		end
		build_table();
		cycle_limit = row_name.size() * 10 + 200;
		repeat (8) @(posedge CLK40M);
		#0.5;
		RESET = 1'b0;
		for (row = 0; row < row_name.size(); row++) begin
			errs_before = error_count;
			run_bus_cycle(row_name[row], row_op[row], row_addr[row], row_data[row], result);
			check_value(row_name[row], row_exp[row], result);
			if (error_count == errs_before) begin
				pass_count++;
				$display("PASS  %s", row_name[row]);
			end else begin
				fail_count++;
				$display("FAIL  %s", row_name[row]);
			end
		end
		$display("Summary: %0d tests, %0d passed, %0d failed", row_name.size(), pass_count,
			fail_count);
		if (fail_count == 0 && error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+source
source/sys1_bus_pkg.sv
source/sys1_rom_pkg.sv
source/sys1_clock_enable.sv
source/sys1_input_ports.sv
source/sys1_program_decrypt.sv
source/sys1_work_ram.sv
source/sys1_main_board.sv
testbench/tb_sys1_main_board.sv

// ==== Makefile ====
# Verilator build and run of the main CPU board testbench
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := tb_sys1_main_board
FILELIST := verilog.f
OBJDIR   := obj_dir
EXE      := $(OBJDIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(EXE))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJDIR)
